// File: compile.f
+incdir+design
+incdir+tb
design/imuldiv_pkg.sv
design/int_mul_iterative.sv
design/int_div_iterative.sv
design/imuldiv_resp_merge.sv
design/imuldiv_top.sv
tb/imuldiv_tb.sv

// File: Makefile
# Verilator build and run of the multiply/divide testbench

SIM = obj_dir/imuldiv_sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  -f compile.f --top-module imuldiv_tb -o imuldiv_sim
	@out="$$(./$(SIM))"; echo "$$out"; \
	  echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

// File: tb/imuldiv_vectors.svh
/* Stimulus rows for the multiply/divide testbench, included inside the tb module.
   Literal widths assume a 32-bit XLEN, and imuldiv_pkg must be imported first. */

`ifndef IMULDIV_VECTORS_SVH
`define IMULDIV_VECTORS_SVH

// row layout {op, operand a, operand b, expected result}
// divides expect {remainder, quotient}
localparam int ROW_W    = 2 + 4 * `IMULDIV_XLEN;
localparam int NUM_VECS = 29;

localparam logic [ROW_W-1:0] VEC_TABLE [NUM_VECS] = '{
  // alternating mul and div keeps both engines busy at once
  {OP_MUL,  32'h00000007, 32'hFFFFFFFD, 64'hFFFFFFFF_FFFFFFEB},
  {OP_DIV,  32'h00000014, 32'h00000003, 64'h00000002_00000006},
  {OP_MUL,  32'h00000000, 32'h12345678, 64'h00000000_00000000},
  {OP_DIV,  32'hFFFFFFEC, 32'h00000003, 64'hFFFFFFFE_FFFFFFFA},
  {OP_MUL,  32'hFFFFFFFF, 32'hFFFFFFFF, 64'h00000000_00000001},
  // same bits as the row above read unsigned
  {OP_DIVU, 32'hFFFFFFEC, 32'h00000003, 64'h00000002_5555554E},
  {OP_MUL,  32'h80000000, 32'h80000000, 64'h40000000_00000000},
  {OP_DIV,  32'h00000014, 32'hFFFFFFFD, 64'h00000002_FFFFFFFA},
  {OP_MUL,  32'h80000000, 32'h00000001, 64'hFFFFFFFF_80000000},
  {OP_DIV,  32'hFFFFFFEC, 32'hFFFFFFFD, 64'hFFFFFFFE_00000006},
  {OP_MUL,  32'h80000000, 32'hFFFFFFFF, 64'h00000000_80000000},
  // divide by zero, quotient all ones and remainder is the dividend
  {OP_DIV,  32'h00000007, 32'h00000000, 64'h00000007_FFFFFFFF},
  {OP_MUL,  32'h7FFFFFFF, 32'h7FFFFFFF, 64'h3FFFFFFF_00000001},
  {OP_DIV,  32'hFFFFFFF9, 32'h00000000, 64'hFFFFFFF9_FFFFFFFF},
  {OP_MUL,  32'h7FFFFFFF, 32'h80000000, 64'hC0000000_80000000},
  {OP_DIVU, 32'h00000005, 32'h00000000, 64'h00000005_FFFFFFFF},
  {OP_MUL,  32'h000003E8, 32'hFFFFFC18, 64'hFFFFFFFF_FFF0BDC0},
  // signed overflow
  {OP_DIV,  32'h80000000, 32'hFFFFFFFF, 64'h00000000_80000000},
  {OP_MUL,  32'h00010000, 32'h00010000, 64'h00000001_00000000},
  {OP_DIVU, 32'h80000000, 32'hFFFFFFFF, 64'h80000000_00000000},
  {OP_MUL,  32'hFFFFFFFF, 32'h00000005, 64'hFFFFFFFF_FFFFFFFB},
  {OP_DIV,  32'hFFFFFFF9, 32'h00000002, 64'hFFFFFFFF_FFFFFFFD},
  // run of divides stalls on the busy divider
  {OP_DIVU, 32'hFFFFFFF9, 32'h00000002, 64'h00000001_7FFFFFFC},
  {OP_DIV,  32'h80000000, 32'h00000002, 64'h00000000_C0000000},
  {OP_DIVU, 32'h80000000, 32'h00000002, 64'h00000000_40000000},
  {OP_DIVU, 32'h00000064, 32'h00000007, 64'h00000002_0000000E},
  {OP_MUL,  32'h12345678, 32'h00000010, 64'h00000001_23456780},
  {OP_DIV,  32'h00000000, 32'h00000005, 64'h00000000_00000000},
  {OP_DIVU, 32'hFFFFFFFF, 32'hFFFFFFFF, 64'h00000000_00000001}
};

`endif

// File: tb/imuldiv_tb.sv
/* Table driven testbench for imuldiv_top with random response back-pressure.
   Responses are expected strictly in table order. */

`timescale 1ns/1ps
`include "imuldiv_consts.svh"

module imuldiv_tb;

  import imuldiv_pkg::*;

  `include "imuldiv_vectors.svh"

  localparam int XLEN          = `IMULDIV_XLEN;
  localparam int ISSUE_TIMEOUT = 500;
  localparam int RESP_TIMEOUT  = 500;

  logic                clk;
  logic                reset;
  imuldiv_op_e         req_op;
  logic [XLEN-1:0]     req_a;
  logic [XLEN-1:0]     req_b;
  logic                req_val;
  logic                req_rdy;
  logic [2*XLEN-1:0]   resp_result;
  logic                resp_val;
  logic                resp_rdy;

  int mismatch_count;
  int other_errors;
  int resp_count;
  int in_flight;
  int max_in_flight;
  bit timed_out;
  int seed_val;

  imuldiv_top i_imuldiv_top (
    .clk         (clk),
    .reset       (reset),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------------------------------------
  // table field access
  // ------------------------------------------------------------
  function automatic imuldiv_op_e row_op(int idx);
    return imuldiv_op_e'(VEC_TABLE[idx][ROW_W-1 -: 2]);
  endfunction

  function automatic logic [XLEN-1:0] row_a(int idx);
    return VEC_TABLE[idx][4*XLEN-1 -: XLEN];
  endfunction

  function automatic logic [XLEN-1:0] row_b(int idx);
    return VEC_TABLE[idx][3*XLEN-1 -: XLEN];
  endfunction

  function automatic logic [2*XLEN-1:0] row_expected(int idx);
    return VEC_TABLE[idx][2*XLEN-1:0];
  endfunction

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  task automatic check_after_reset();
    imuldiv_op_e op;
    for (int k = 0; k < 3; k++) begin
      @(negedge clk);
      op     = imuldiv_op_e'(k);
      req_op = op;
      #1;
      if (resp_val) begin
        $display("resp_val is high after reset at %0t", $time);
        other_errors++;
      end
      if (!req_rdy) begin
        $display("req_rdy is low after reset for %s at %0t", op.name(), $time);
        other_errors++;
      end
    end
  endtask

  task automatic compare_response(int idx, logic [2*XLEN-1:0] got);
    imuldiv_op_e       op;
    logic [2*XLEN-1:0] exp;
    op  = row_op(idx);
    exp = row_expected(idx);
    if (got !== exp) begin
      $display("Mismatch at %0t: row %0d %s a=%h b=%h expected %h received %h",
               $time, idx, op.name(), row_a(idx), row_b(idx), exp, got);
      mismatch_count++;
    end
  endtask

  // present each row until accepted
  // the next row goes out on the following falling edge
  task automatic issue_requests();
    int waited;
    bit accepted;
    for (int i = 0; i < NUM_VECS && !timed_out; i++) begin
      @(negedge clk);
      req_op  = row_op(i);
      req_a   = row_a(i);
      req_b   = row_b(i);
      req_val = 1'b1;
      waited   = 0;
      accepted = 1'b0;
      while (!accepted && !timed_out) begin
        @(posedge clk);
        if (req_rdy) begin
          accepted = 1'b1;
        end else begin
          waited++;
          if (waited >= ISSUE_TIMEOUT) begin
            $display("timeout: row %0d not accepted within %0d cycles", i, waited);
            other_errors++;
            timed_out = 1'b1;
          end
        end
      end
    end
    @(negedge clk);
    req_val = 1'b0;
  endtask

  // consumes responses in order
  // a stalled response must stay unchanged
  task automatic check_responses();
    int                idle;
    bit                stalled;
    logic [2*XLEN-1:0] held;
    idle    = 0;
    stalled = 1'b0;
    held    = '0;
    while (resp_count < NUM_VECS && !timed_out) begin
      @(posedge clk);
      if (stalled && (!resp_val || resp_result !== held)) begin
        $display("Mismatch at %0t: row %0d changed while stalled, held %h now %h",
                 $time, resp_count, held, resp_result);
        mismatch_count++;
      end
      if (resp_val && resp_rdy) begin
        compare_response(resp_count, resp_result);
        resp_count++;
        idle    = 0;
        stalled = 1'b0;
      end else begin
        stalled = resp_val;
        held    = resp_result;
        idle++;
        if (idle >= RESP_TIMEOUT) begin
          $display("timeout: no response for row %0d within %0d cycles", resp_count, idle);
          other_errors++;
          timed_out = 1'b1;
        end
      end
    end
  endtask

  // nothing more may come out within two operation lengths
  task automatic check_no_extra_responses();
    bit seen;
    seen = 1'b0;
    repeat (2 * `IMULDIV_ITERS) begin
      @(posedge clk);
      if (resp_val && !seen) begin
        $display("unexpected extra response %h at %0t", resp_result, $time);
        other_errors++;
        seen = 1'b1;
      end
    end
  endtask

  task automatic report_and_finish();
    $display("errors: %0d mismatches, %0d other failures, %0d of %0d responses",
             mismatch_count, other_errors, resp_count, NUM_VECS);
    if (mismatch_count == 0 && other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // ------------------------------------------------------------
  // outstanding operations seen at the top level handshakes
  // ------------------------------------------------------------
  initial begin : track_in_flight
    forever begin
      @(posedge clk);
      if (!reset) begin
        if (req_val && req_rdy && !(resp_val && resp_rdy)) begin
          in_flight++;
        end else if (!(req_val && req_rdy) && resp_val && resp_rdy) begin
          in_flight--;
        end
        if (in_flight > max_in_flight) begin
          max_in_flight = in_flight;
        end
      end
    end
  end

  // ready low about one cycle in four
  initial begin : drive_back_pressure
    seed_val = $urandom(32'h9fd7);
    forever begin
      @(negedge clk);
      resp_rdy = ($urandom % 4) != 0;
    end
  end

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    reset          = 1'b1;
    req_op         = OP_MUL;
    req_a          = '0;
    req_b          = '0;
    req_val        = 1'b0;
    resp_rdy       = 1'b1;
    mismatch_count = 0;
    other_errors   = 0;
    resp_count     = 0;
    in_flight      = 0;
    max_in_flight  = 0;
    timed_out      = 1'b0;

    // three rising edges in reset
    repeat (3) @(negedge clk);
    reset = 1'b0;

    check_after_reset();
    fork
      issue_requests();
      check_responses();
    join

    if (!timed_out) begin
      check_no_extra_responses();
      if (max_in_flight < 2) begin
        $display("multiply and divide were never in flight together");
        other_errors++;
      end
    end
    report_and_finish();
  end

endmodule

// File: design/imuldiv_top.sv
/* Iterative multiply/divide unit with in-order val/rdy responses.
   Latency is 33 cycles or more, one multiply and one divide may overlap. */

`timescale 1ns/1ps
`include "imuldiv_consts.svh"

module imuldiv_top (
  input  logic                         clk,
  input  logic                         reset,
  input  imuldiv_pkg::imuldiv_op_e     req_op,
  input  logic [`IMULDIV_XLEN-1:0]     req_a,
  input  logic [`IMULDIV_XLEN-1:0]     req_b,
  input  logic                         req_val,
  output logic                         req_rdy,
  output logic [2*`IMULDIV_XLEN-1:0]   resp_result,
  output logic                         resp_val,
  input  logic                         resp_rdy
);

  // ------------------------------------------------------------
  // engine handshakes, all routed by the merge
  // ------------------------------------------------------------
  logic                       mul_req_val;
  logic                       mul_req_rdy;
  logic                       div_req_val;
  logic                       div_req_rdy;
  logic                       div_signed;
  logic [2*`IMULDIV_XLEN-1:0] mul_result;
  logic [2*`IMULDIV_XLEN-1:0] div_result;
  logic                       mul_resp_val;
  logic                       div_resp_val;
  logic                       mul_resp_rdy;
  logic                       div_resp_rdy;

  imuldiv_resp_merge i_merge (
    .clk          (clk),
    .reset        (reset),
    .req_op       (req_op),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .mul_req_val  (mul_req_val),
    .mul_req_rdy  (mul_req_rdy),
    .div_req_val  (div_req_val),
    .div_req_rdy  (div_req_rdy),
    .div_signed   (div_signed),
    .mul_result   (mul_result),
    .div_result   (div_result),
    .mul_resp_val (mul_resp_val),
    .div_resp_val (div_resp_val),
    .mul_resp_rdy (mul_resp_rdy),
    .div_resp_rdy (div_resp_rdy),
    .resp_result  (resp_result),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy)
  );

  // operands fan out to both engines
  int_mul_iterative i_mul (
    .clk      (clk),
    .reset    (reset),
    .a        (req_a),
    .b        (req_b),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .result   (mul_result),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy)
  );

  int_div_iterative i_div (
    .clk       (clk),
    .reset     (reset),
    .a         (req_a),
    .b         (req_b),
    .is_signed (div_signed),
    .req_val   (div_req_val),
    .req_rdy   (div_req_rdy),
    .result    (div_result),
    .resp_val  (div_resp_val),
    .resp_rdy  (div_resp_rdy)
  );

endmodule

// File: design/imuldiv_resp_merge.sv
/* Dispatches requests by opcode and returns responses in issue order.
   At most one request per engine is outstanding. ORDER_DEPTH must be 2 or more. */

`timescale 1ns/1ps
`include "imuldiv_consts.svh"

module imuldiv_resp_merge #(
  parameter int ORDER_DEPTH = `IMULDIV_ORDER_DEPTH
) (
  input  logic                         clk,
  input  logic                         reset,
  input  imuldiv_pkg::imuldiv_op_e     req_op,
  input  logic                         req_val,
  output logic                         req_rdy,
  output logic                         mul_req_val,
  input  logic                         mul_req_rdy,
  output logic                         div_req_val,
  input  logic                         div_req_rdy,
  output logic                         div_signed,
  input  logic [2*`IMULDIV_XLEN-1:0]   mul_result,
  input  logic [2*`IMULDIV_XLEN-1:0]   div_result,
  input  logic                         mul_resp_val,
  input  logic                         div_resp_val,
  output logic                         mul_resp_rdy,
  output logic                         div_resp_rdy,
  output logic [2*`IMULDIV_XLEN-1:0]   resp_result,
  output logic                         resp_val,
  input  logic                         resp_rdy
);

  import imuldiv_pkg::*;

  localparam int   PTR_W   = $clog2(ORDER_DEPTH);
  localparam int   CNT_W   = $clog2(ORDER_DEPTH + 1);
  localparam logic ENG_MUL = 1'b0;
  localparam logic ENG_DIV = 1'b1;

  logic             id_mem [ORDER_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;

  logic sel_div;
  logic full;
  logic empty;
  logic head_id;
  logic push;
  logic pop;

  // ------------------------------------------------------------
  // request dispatch
  // ------------------------------------------------------------
  assign sel_div     = (req_op != OP_MUL);
  assign div_signed  = (req_op == OP_DIV);
  assign full        = (cnt_q == CNT_W'(ORDER_DEPTH));
  assign empty       = (cnt_q == '0);
  assign req_rdy     = !full && (sel_div ? div_req_rdy : mul_req_rdy);
  assign mul_req_val = req_val && !full && !sel_div;
  assign div_req_val = req_val && !full && sel_div;
  assign push        = req_val && req_rdy;

  // ------------------------------------------------------------
  // response from the head engine only
  // ------------------------------------------------------------
  assign head_id      = id_mem[rd_ptr_q];
  assign resp_val     = !empty && ((head_id == ENG_DIV) ? div_resp_val : mul_resp_val);
  assign resp_result  = (head_id == ENG_DIV) ? div_result : mul_result;
  // engine not at head sees rdy low and keeps waiting in done
  assign mul_resp_rdy = resp_rdy && !empty && (head_id == ENG_MUL);
  assign div_resp_rdy = resp_rdy && !empty && (head_id == ENG_DIV);
  assign pop          = resp_val && resp_rdy;

  // issue-order queue storage
  always_ff @(posedge clk) begin
    if (push) begin
      id_mem[wr_ptr_q] <= sel_div ? ENG_DIV : ENG_MUL;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(ORDER_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(ORDER_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leave the count unchanged
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // a push at full or a pop at empty drives the count past the depth
  a_count_range: assert property (@(posedge clk) disable iff (reset)
    cnt_q <= CNT_W'(ORDER_DEPTH));
  // a finished engine always has its id waiting in the queue
  a_resp_queued: assert property (@(posedge clk) disable iff (reset)
    (mul_resp_val || div_resp_val) |-> !empty);

endmodule

// File: design/int_div_iterative.sv
/* Restoring divider on magnitudes, one quotient bit per cycle, no early exit.
   Divide by zero gives all-ones quotient and the dividend as remainder. */

`timescale 1ns/1ps
`include "imuldiv_consts.svh"

module int_div_iterative (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [`IMULDIV_XLEN-1:0]     a,
  input  logic [`IMULDIV_XLEN-1:0]     b,
  input  logic                         is_signed,
  input  logic                         req_val,
  output logic                         req_rdy,
  output logic [2*`IMULDIV_XLEN-1:0]   result,
  output logic                         resp_val,
  input  logic                         resp_rdy
);

  import imuldiv_pkg::*;

  localparam int XLEN  = `IMULDIV_XLEN;
  localparam int CNT_W = $clog2(`IMULDIV_ITERS + 1);

  iter_state_e         state_q;
  logic [CNT_W-1:0]    count_q;
  // dividend shifts out the top while quotient bits enter the bottom
  logic [XLEN-1:0]     dvd_q;
  logic [XLEN-1:0]     rem_q;
  logic [XLEN-1:0]     dvsr_q;
  logic                q_neg_q;
  logic                r_neg_q;

  logic                a_neg;
  logic                b_neg;
  logic [XLEN-1:0]     a_mag;
  logic [XLEN-1:0]     b_mag;
  logic [XLEN:0]       rem_shift;
  logic [XLEN:0]       diff;
  logic                take;
  logic [XLEN-1:0]     rem_next;
  logic [XLEN-1:0]     quo_next;
  logic                last_step;
  logic                req_go;

  assign req_rdy   = (state_q == ST_IDLE);
  assign resp_val  = (state_q == ST_DONE);
  assign req_go    = req_val && req_rdy;
  assign last_step = (count_q == CNT_W'(`IMULDIV_ITERS - 1));

  // ------------------------------------------------------------
  // operand conditioning
  // ------------------------------------------------------------
  // unsigned divide sees raw bit patterns
  assign a_neg = is_signed && a[XLEN-1];
  assign b_neg = is_signed && b[XLEN-1];
  assign a_mag = a_neg ? -a : a;
  assign b_mag = b_neg ? -b : b;

  // ------------------------------------------------------------
  // one restoring step
  // ------------------------------------------------------------
  // extra top bit keeps the compare correct for large unsigned divisors
  assign rem_shift = {rem_q, dvd_q[XLEN-1]};
  assign diff      = rem_shift - {1'b0, dvsr_q};
  assign take      = !diff[XLEN];
  assign rem_next  = take ? diff[XLEN-1:0] : rem_shift[XLEN-1:0];
  assign quo_next  = {dvd_q[XLEN-2:0], take};

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req_go) begin
            state_q <= ST_CALC;
            count_q <= '0;
          end
        end
        ST_CALC: begin
          count_q <= count_q + 1'b1;
          if (last_step) begin
            state_q <= ST_DONE;
          end
        end
        ST_DONE: begin
          if (resp_rdy) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_go) begin
      dvd_q   <= a_mag;
      rem_q   <= '0;
      dvsr_q  <= b_mag;
      // zero divisor keeps the all-ones quotient unsigned
      q_neg_q <= (a_neg ^ b_neg) && (b != '0);
      r_neg_q <= a_neg;
    end else if (state_q == ST_CALC) begin
      // signs applied on the way into done
      rem_q <= (last_step && r_neg_q) ? -rem_next : rem_next;
      dvd_q <= (last_step && q_neg_q) ? -quo_next : quo_next;
    end
  end

  // remainder high, quotient low
  assign result = {rem_q, dvd_q};

  a_count_range: assert property (@(posedge clk) disable iff (reset)
    count_q <= CNT_W'(`IMULDIV_ITERS));

endmodule

// File: design/int_mul_iterative.sv
/* Signed shift-add multiplier, one multiplier bit per cycle, no early exit.
   Result valid 33 cycles after accept and held until resp_rdy. */

`timescale 1ns/1ps
`include "imuldiv_consts.svh"

module int_mul_iterative (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [`IMULDIV_XLEN-1:0]     a,
  input  logic [`IMULDIV_XLEN-1:0]     b,
  input  logic                         req_val,
  output logic                         req_rdy,
  output logic [2*`IMULDIV_XLEN-1:0]   result,
  output logic                         resp_val,
  input  logic                         resp_rdy
);

  import imuldiv_pkg::*;

  localparam int XLEN  = `IMULDIV_XLEN;
  localparam int CNT_W = $clog2(`IMULDIV_ITERS + 1);

  iter_state_e         state_q;
  logic [CNT_W-1:0]    count_q;
  logic [2*XLEN-1:0]   mcand_q;
  logic [XLEN-1:0]     mplier_q;
  logic [2*XLEN-1:0]   acc_q;
  logic                neg_q;

  logic [XLEN-1:0]     a_mag;
  logic [XLEN-1:0]     b_mag;
  logic [2*XLEN-1:0]   acc_next;
  logic                last_step;
  logic                req_go;

  // ------------------------------------------------------------
  // handshake and step decode
  // ------------------------------------------------------------
  assign req_rdy   = (state_q == ST_IDLE);
  assign resp_val  = (state_q == ST_DONE);
  assign req_go    = req_val && req_rdy;
  assign last_step = (count_q == CNT_W'(`IMULDIV_ITERS - 1));

  // magnitudes, most negative value maps to 2^(XLEN-1) unsigned
  assign a_mag = a[XLEN-1] ? -a : a;
  assign b_mag = b[XLEN-1] ? -b : b;

  // add shifted multiplicand when current multiplier bit is set
  assign acc_next = acc_q + (mplier_q[0] ? mcand_q : '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req_go) begin
            state_q <= ST_CALC;
            count_q <= '0;
          end
        end
        ST_CALC: begin
          count_q <= count_q + 1'b1;
          if (last_step) begin
            state_q <= ST_DONE;
          end
        end
        ST_DONE: begin
          if (resp_rdy) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (req_go) begin
      mcand_q  <= {{XLEN{1'b0}}, a_mag};
      mplier_q <= b_mag;
      acc_q    <= '0;
      // product is negative when exactly one operand is
      neg_q    <= a[XLEN-1] ^ b[XLEN-1];
    end else if (state_q == ST_CALC) begin
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
      // sign fix folded into the final step
      acc_q    <= (last_step && neg_q) ? -acc_next : acc_next;
    end
  end

  assign result = acc_q;

  // a pending response stays up and unchanged until taken
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(result));

endmodule

// File: design/imuldiv_pkg.sv
/* Types shared by the multiply/divide engines, the merge and the testbench.
   Opcode encoding 2'b11 is unused and must not be issued. */

package imuldiv_pkg;

  // ------------------------------------------------------------
  // request opcode
  // ------------------------------------------------------------
  // OP_MUL gives the full signed 64-bit product
  // both divides pack remainder high and quotient low
  typedef enum logic [1:0] {
    OP_MUL  = 2'd0,
    OP_DIV  = 2'd1,
    OP_DIVU = 2'd2
  } imuldiv_op_e;

  // ------------------------------------------------------------
  // engine FSM state
  // ------------------------------------------------------------
  // idle accepts, calc iterates, done holds result until taken
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } iter_state_e;

endpackage

// File: design/imuldiv_consts.svh
/* Widths and depths shared by the multiply/divide unit.
   ITERS must equal XLEN since the engines retire one bit per cycle. */

`ifndef IMULDIV_CONSTS_SVH
`define IMULDIV_CONSTS_SVH

// ------------------------------------------------------------
// datapath width
// ------------------------------------------------------------
`define IMULDIV_XLEN 32

// calculation cycles per operation
`define IMULDIV_ITERS 32

// ------------------------------------------------------------
// response ordering
// ------------------------------------------------------------
// default entries in the issue-order queue
`define IMULDIV_ORDER_DEPTH 4

`endif
